// File: src.f
+incdir+test
common/uop_pkg.sv
common/exec_pkg.sv
logic/phys_reg_file.sv
alu/alu_unit.sv
logic/alu_exec_top.sv
test/alu_exec_tb.sv

// File: test/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Shadow copies of the register file and the flag register
data_t shadow_regs [64];
nzcv_t shadow_flags;

// Expected writebacks, oldest first
preg_t exp_index_q [$];
data_t exp_data_q [$];
logic  exp_fv_q [$];
nzcv_t exp_flags_q [$];

// Result and N/Z/C/V of one micro-op, straight from the operation rules
function automatic void ref_alu(input uop_opcode_t op, input uop_ctrl_t ctrl,
                                input imm16_t imm, input data_t a, input data_t b_reg,
                                input data_t c, output data_t res, output nzcv_t nzcv);
    data_t      b;
    logic [64:0] wide;
    logic [64:0] swide;
    logic       carry;
    logic       ovf;
    int         lsb;
    int         msb;
    int         hw;
    int         shamt;
    b     = ctrl[15] ? {48'b0, imm} : b_reg;
    lsb   = ctrl[5:0];
    msb   = ctrl[11:6];
    hw    = ctrl[13:12];
    shamt = b[5:0];
    carry = 1'b0;
    ovf   = 1'b0;
    res   = '0;
    case (op)
        ALU_ADD: begin
            wide  = {1'b0, a} + {1'b0, b};
            res   = wide[63:0];
            carry = wide[64];
            // Signed overflow shows as a mismatch between the two top bits
            swide = {a[63], a} + {b[63], b};
            ovf   = swide[64] ^ swide[63];
        end
        ALU_SUB: begin
            // Subtract as a plus the inverse of b plus one, so the carry out means no borrow
            wide  = {1'b0, a} + {1'b0, ~b} + 65'd1;
            res   = wide[63:0];
            carry = wide[64];
            swide = {a[63], a} - {b[63], b};
            ovf   = swide[64] ^ swide[63];
        end
        ALU_AND: res = a & b;
        ALU_ORR: res = a | b;
        ALU_EOR: res = a ^ b;
        ALU_MVN: res = ~a;
        ALU_UBFM: begin
            for (int i = lsb; i <= msb; i++) begin
                res[i - lsb] = a[i];
            end
        end
        ALU_ASR: begin
            for (int i = 0; i < 64; i++) begin
                res[i] = (i + shamt > 63) ? a[63] : a[i + shamt];
            end
        end
        ALU_MOVZ: res[hw*16 +: 16] = b[15:0];
        ALU_MOVK: begin
            res = c;
            res[hw*16 +: 16] = b[15:0];
        end
        default: res = '0;
    endcase
    nzcv = {res[63], (res == 64'd0), carry, ovf};
endfunction

// Runs one issued micro-op through the shadow state and queues its writeback
function automatic void predict_issue(input uop_opcode_t op, input uop_ctrl_t ctrl,
                                      input imm16_t imm, input preg_t src_a,
                                      input preg_t src_b, input preg_t src_c,
                                      input preg_t dest);
    data_t res;
    nzcv_t nzcv;
    ref_alu(op, ctrl, imm, shadow_regs[src_a], shadow_regs[src_b], shadow_regs[src_c],
            res, nzcv);
    if (ctrl[14]) begin
        shadow_flags = nzcv;
    end
    shadow_regs[dest] = res;
    exp_index_q.push_back(dest);
    exp_data_q.push_back(res);
    exp_fv_q.push_back(ctrl[14]);
    exp_flags_q.push_back(shadow_flags);
endfunction

`endif

// File: test/alu_exec_tb.sv
module alu_exec_tb
    import uop_pkg::*, exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_RANDOM      = 300;
    localparam int DIRECTED_ISSUES = 170;
    // Each micro-op needs three cycles here, so ten is a wide budget
    localparam int WATCHDOG_CYCLES = (DIRECTED_ISSUES + NUM_RANDOM) * 10 + 200;

    logic        clk_in;
    logic        rst_n;
    logic        issue_valid;
    uop_opcode_t issue_op;
    uop_ctrl_t   issue_ctrl;
    imm16_t      issue_imm;
    preg_t       issue_src_a;
    preg_t       issue_src_b;
    preg_t       issue_src_c;
    preg_t       issue_dest;
    logic        issue_ready;
    logic        wb_valid;
    preg_t       wb_index;
    data_t       wb_data;
    logic        flags_valid;
    nzcv_t       flags;

    int error_count       = 0;
    int check_count       = 0;
    int issued_count      = 0;
    int tests_run         = 0;
    int tests_failed      = 0;
    int test_start_errors = 0;

    `include "alu_model.svh"

    alu_exec_top #(
        .NUM_PREGS (64)
    ) DUT (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_ctrl  (issue_ctrl),
        .issue_imm   (issue_imm),
        .issue_src_a (issue_src_a),
        .issue_src_b (issue_src_b),
        .issue_src_c (issue_src_c),
        .issue_dest  (issue_dest),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb_index    (wb_index),
        .wb_data     (wb_data),
        .flags_valid (flags_valid),
        .flags       (flags)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("[%0t] watchdog expired after %0d micro-ops", $time, issued_count);
        $display("TEST FAIL");
        $finish;
    end

    // ************************************************************************
    // Checking
    // ************************************************************************

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Outputs are sampled at the falling edge, away from the register updates
    always @(negedge clk_in) begin
        if (rst_n && wb_valid) begin
            if (exp_data_q.size() == 0) begin
                report_error("writeback arrived with no micro-op outstanding");
            end else begin
                check_value("wb_index", wb_index, exp_index_q.pop_front());
                check_value("wb_data", wb_data, exp_data_q.pop_front());
                check_value("flags_valid", flags_valid, exp_fv_q.pop_front());
                check_value("flags", flags, exp_flags_q.pop_front());
            end
        end else if (rst_n && flags_valid) begin
            report_error("flags_valid pulsed without a writeback");
        end
    end

    task automatic end_test(input string name);
        tests_run++;
        if (error_count != test_start_errors) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (error_count == test_start_errors) ? "ok" : "failed",
                 error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    function automatic uop_ctrl_t make_ctrl(input logic set_flags, input logic use_imm,
                                            input int hw, input int msb, input int lsb);
        return {use_imm, set_flags, hw[1:0], msb[5:0], lsb[5:0]};
    endfunction

    task automatic issue_uop(input uop_opcode_t op, input uop_ctrl_t ctrl, input imm16_t imm,
                             input preg_t src_a, input preg_t src_b, input preg_t src_c,
                             input preg_t dest);
        @(negedge clk_in);
        while (!issue_ready) begin
            @(negedge clk_in);
        end
        @(posedge clk_in);
        issue_valid <= 1'b1;
        issue_op    <= op;
        issue_ctrl  <= ctrl;
        issue_imm   <= imm;
        issue_src_a <= src_a;
        issue_src_b <= src_b;
        issue_src_c <= src_c;
        issue_dest  <= dest;
        predict_issue(op, ctrl, imm, src_a, src_b, src_c, dest);
        issued_count++;
        @(posedge clk_in);
        issue_valid <= 1'b0;
        @(negedge clk_in);
        check_value("issue_ready", issue_ready, 64'd0);
        if (!wb_valid) begin
            report_error("no writeback in the cycle after an accepted micro-op");
        end
    endtask

    // Builds a 64-bit constant with one MOVZ and three MOVK
    task automatic load_reg(input preg_t dest, input data_t value);
        issue_uop(ALU_MOVZ, make_ctrl(0, 1, 0, 0, 0), value[15:0], 0, 0, 0, dest);
        for (int hw = 1; hw < 4; hw++) begin
            issue_uop(ALU_MOVK, make_ctrl(0, 1, hw, 0, 0), value[hw*16 +: 16], 0, 0, dest,
                      dest);
        end
    endtask

    initial begin
        data_t value;
        int    lsb;
        int    msb;
        issue_valid = 1'b0;
        issue_op    = ALU_ADD;
        issue_ctrl  = '0;
        issue_imm   = '0;
        issue_src_a = '0;
        issue_src_b = '0;
        issue_src_c = '0;
        issue_dest  = '0;
        rst_n       = 1'b0;
        void'($urandom(32'h574));
        for (int i = 0; i < 64; i++) begin
            shadow_regs[i] = '0;
        end
        shadow_flags = '0;
        repeat (5) @(posedge clk_in);
        rst_n <= 1'b1;

        @(negedge clk_in);
        check_value("issue_ready", issue_ready, 64'd1);
        check_value("wb_valid", wb_valid, 64'd0);
        check_value("flags_valid", flags_valid, 64'd0);
        check_value("flags", flags, 64'd0);
        end_test("reset state");

        for (int hw = 0; hw < 4; hw++) begin
            issue_uop(ALU_MOVZ, make_ctrl(0, 1, hw, 0, 0), $urandom(), 0, 0, 0, hw + 1);
        end
        for (int r = 5; r < 9; r++) begin
            load_reg(r, {$urandom(), $urandom()});
        end
        // MOVK with b from a register rather than the immediate
        issue_uop(ALU_MOVZ, make_ctrl(0, 1, 0, 0, 0), 16'hbeef, 0, 0, 0, 9);
        issue_uop(ALU_MOVK, make_ctrl(0, 0, 2, 0, 0), 0, 0, 9, 5, 5);
        for (int r = 1; r < 9; r++) begin
            issue_uop(ALU_ORR, make_ctrl(0, 1, 0, 0, 0), 0, r, 0, 0, r);
        end
        end_test("move-wide loads");

        load_reg(10, 64'hffff_ffff_ffff_ffff);
        load_reg(11, 64'd1);
        load_reg(12, 64'h7fff_ffff_ffff_ffff);
        load_reg(13, 64'h8000_0000_0000_0000);
        load_reg(14, 64'd5);
        load_reg(15, 64'd3);
        issue_uop(ALU_ADD, make_ctrl(1, 0, 0, 0, 0), 0, 10, 11, 0, 30);
        issue_uop(ALU_ADD, make_ctrl(1, 0, 0, 0, 0), 0, 12, 11, 0, 31);
        issue_uop(ALU_ADD, make_ctrl(1, 0, 0, 0, 0), 0, 13, 13, 0, 32);
        issue_uop(ALU_SUB, make_ctrl(1, 0, 0, 0, 0), 0, 14, 14, 0, 33);
        issue_uop(ALU_SUB, make_ctrl(1, 0, 0, 0, 0), 0, 15, 14, 0, 34);
        issue_uop(ALU_SUB, make_ctrl(1, 0, 0, 0, 0), 0, 13, 11, 0, 35);
        issue_uop(ALU_ADD, make_ctrl(0, 0, 0, 0, 0), 0, 12, 11, 0, 36);
        issue_uop(ALU_SUB, make_ctrl(1, 1, 0, 0, 0), 5, 14, 0, 0, 37);
        end_test("add and subtract flags");

        value = {$urandom(), $urandom()};
        load_reg(20, value & 64'h7fff_ffff_ffff_ffff);
        load_reg(21, value | 64'h8000_0000_0000_0000);
        load_reg(22, {$urandom(), $urandom()});
        load_reg(23, {$urandom(), $urandom()});
        issue_uop(ALU_AND, make_ctrl(1, 0, 0, 0, 0), 0, 20, 22, 0, 40);
        issue_uop(ALU_ORR, make_ctrl(1, 0, 0, 0, 0), 0, 21, 23, 0, 41);
        issue_uop(ALU_EOR, make_ctrl(0, 0, 0, 0, 0), 0, 22, 23, 0, 42);
        issue_uop(ALU_AND, make_ctrl(1, 1, 0, 0, 0), $urandom(), 22, 0, 0, 43);
        issue_uop(ALU_ORR, make_ctrl(0, 1, 0, 0, 0), $urandom(), 23, 0, 0, 44);
        issue_uop(ALU_EOR, make_ctrl(1, 1, 0, 0, 0), $urandom(), 21, 0, 0, 45);
        issue_uop(ALU_MVN, make_ctrl(1, 0, 0, 0, 0), 0, 22, 0, 0, 46);
        for (int sh = 0; sh < 64; sh++) begin
            issue_uop(ALU_ASR, make_ctrl(sh[0], 1, 0, 0, 0), sh, 20 + sh % 2, 0, 0, 47);
        end
        for (int n = 0; n < 14; n++) begin
            if (n < 10) begin
                lsb = $urandom_range(0, 63);
                msb = $urandom_range(lsb, 63);
            end else begin
                // Reversed range, the extract gives zero
                lsb = $urandom_range(1, 63);
                msb = $urandom_range(0, lsb - 1);
            end
            issue_uop(ALU_UBFM, make_ctrl(1, 0, 0, msb, lsb), 0, 21 + n % 3, 0, 0, 48);
        end
        end_test("logic, shift and extract");

        // Small index range so that later micro-ops read earlier results
        for (int n = 0; n < NUM_RANDOM; n++) begin
            issue_uop(uop_opcode_t'($urandom_range(0, 11)), $urandom(), $urandom(),
                      $urandom_range(0, 15), $urandom_range(0, 15), $urandom_range(0, 15),
                      $urandom_range(0, 15));
        end
        end_test("random sequence");

        repeat (3) @(negedge clk_in);
        if (exp_data_q.size() != 0) begin
            report_error($sformatf("%0d writebacks never arrived", exp_data_q.size()));
        end
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: logic/alu_exec_top.sv
module alu_exec_top
    import uop_pkg::*, exec_pkg::*;
#(
    parameter int NUM_PREGS = 64
) (
    input  logic        clk_in,
    input  logic        rst_n,

    // Issue side
    input  logic        issue_valid,
    input  uop_opcode_t issue_op,
    input  uop_ctrl_t   issue_ctrl,
    input  imm16_t      issue_imm,
    input  preg_t       issue_src_a,
    input  preg_t       issue_src_b,
    input  preg_t       issue_src_c,
    input  preg_t       issue_dest,
    output logic        issue_ready,

    // Writeback and flags
    output logic        wb_valid,
    output preg_t       wb_index,
    output data_t       wb_data,
    output logic        flags_valid,
    output nzcv_t       flags
);

    preg_t rd_index_a;
    preg_t rd_index_b;
    preg_t rd_index_c;
    data_t rd_data_a;
    data_t rd_data_b;
    data_t rd_data_c;

    // The writeback port doubles as the register file write port
    phys_reg_file #(
        .NUM_PREGS (NUM_PREGS)
    ) u_prf (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .rd_index_a (rd_index_a),
        .rd_index_b (rd_index_b),
        .rd_index_c (rd_index_c),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .rd_data_c  (rd_data_c),
        .wr_en      (wb_valid),
        .wr_index   (wb_index),
        .wr_data    (wb_data)
    );

    alu_unit u_alu (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_ctrl  (issue_ctrl),
        .issue_imm   (issue_imm),
        .issue_src_a (issue_src_a),
        .issue_src_b (issue_src_b),
        .issue_src_c (issue_src_c),
        .issue_dest  (issue_dest),
        .rd_index_a  (rd_index_a),
        .rd_index_b  (rd_index_b),
        .rd_index_c  (rd_index_c),
        .opnd_a      (rd_data_a),
        .opnd_b      (rd_data_b),
        .opnd_c      (rd_data_c),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb_index    (wb_index),
        .wb_data     (wb_data),
        .flags_valid (flags_valid),
        .flags       (flags)
    );

endmodule

// File: alu/alu_unit.sv
module alu_unit
    import uop_pkg::*, exec_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst_n,

    input  logic        issue_valid,
    input  uop_opcode_t issue_op,
    input  uop_ctrl_t   issue_ctrl,
    input  imm16_t      issue_imm,
    input  preg_t       issue_src_a,
    input  preg_t       issue_src_b,
    input  preg_t       issue_src_c,
    input  preg_t       issue_dest,

    output preg_t       rd_index_a,
    output preg_t       rd_index_b,
    output preg_t       rd_index_c,
    input  data_t       opnd_a,
    input  data_t       opnd_b,
    input  data_t       opnd_c,

    output logic        issue_ready,
    output logic        wb_valid,
    output preg_t       wb_index,
    output data_t       wb_data,
    output logic        flags_valid,
    output nzcv_t       flags
);

    data_t    opnd_b_sel;
    data_t    imm_word;
    bit_pos_t lsb;
    bit_pos_t msb;
    bit_pos_t field_w;
    bit_pos_t hw_shift;
    data_t    ubfm_mask;
    logic     carry_add;
    data_t    res_add;
    data_t    res_sub;
    data_t    res_and;
    data_t    res_orr;
    data_t    res_eor;
    data_t    res_mvn;
    data_t    res_ubfm;
    data_t    res_asr;
    data_t    res_movz;
    data_t    res_movk;
    data_t    result;
    nzcv_t    flags_next;
    logic     set_flags;

    // Operands come straight from the register file in the issue cycle
    assign rd_index_a = issue_src_a;
    assign rd_index_b = issue_src_b;
    assign rd_index_c = issue_src_c;

    assign opnd_b_sel = ctrl_use_imm(issue_ctrl) ? data_t'(issue_imm) : opnd_b;
    assign set_flags  = ctrl_set_flags(issue_ctrl);

    // ************************************************************************
    // Datapath, all ten operations in parallel
    // ************************************************************************

    assign {carry_add, res_add} = {1'b0, opnd_a} + {1'b0, opnd_b_sel};
    assign res_sub = opnd_a - opnd_b_sel;
    assign res_and = opnd_a & opnd_b_sel;
    assign res_orr = opnd_a | opnd_b_sel;
    assign res_eor = opnd_a ^ opnd_b_sel;
    assign res_mvn = ~opnd_a;

    // Extract keeps msb-lsb+1 bits; the mask is built so a full 64-bit field works
    assign lsb       = ctrl_lsb(issue_ctrl);
    assign msb       = ctrl_msb(issue_ctrl);
    assign field_w   = msb - lsb;
    assign ubfm_mask = ~({{(DATA_W-1){1'b1}}, 1'b0} << field_w);
    assign res_ubfm  = (msb < lsb) ? '0 : ((opnd_a >> lsb) & ubfm_mask);

    assign res_asr = data_t'($signed(opnd_a) >>> opnd_b_sel[5:0]);

    // Move-wide places the low half-word of b at 16 * hw
    assign imm_word = data_t'(opnd_b_sel[15:0]);
    assign hw_shift = {ctrl_hw(issue_ctrl), 4'b0000};
    assign res_movz = imm_word << hw_shift;
    assign res_movk = (opnd_c & ~(data_t'(16'hffff) << hw_shift)) | res_movz;

    always_comb begin
        case (issue_op)
            ALU_ADD:  result = res_add;
            ALU_SUB:  result = res_sub;
            ALU_AND:  result = res_and;
            ALU_ORR:  result = res_orr;
            ALU_EOR:  result = res_eor;
            ALU_MVN:  result = res_mvn;
            ALU_UBFM: result = res_ubfm;
            ALU_ASR:  result = res_asr;
            ALU_MOVZ: result = res_movz;
            ALU_MOVK: result = res_movk;
            default:  result = '0;
        endcase
    end

    // C and V only carry meaning for the add and subtract paths
    always_comb begin
        flags_next         = '0;
        flags_next[NZCV_N] = result[DATA_W-1];
        flags_next[NZCV_Z] = (result == '0);
        case (issue_op)
            ALU_ADD: begin
                flags_next[NZCV_C] = carry_add;
                flags_next[NZCV_V] = (opnd_a[DATA_W-1] == opnd_b_sel[DATA_W-1]) &&
                                     (opnd_a[DATA_W-1] != res_add[DATA_W-1]);
            end
            ALU_SUB: begin
                // Carry set means no borrow
                flags_next[NZCV_C] = (opnd_a >= opnd_b_sel);
                flags_next[NZCV_V] = (opnd_a[DATA_W-1] != opnd_b_sel[DATA_W-1]) &&
                                     (opnd_a[DATA_W-1] != res_sub[DATA_W-1]);
            end
            default: begin
                flags_next[NZCV_C] = 1'b0;
                flags_next[NZCV_V] = 1'b0;
            end
        endcase
    end

    // Control state and the flag register
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid    <= 1'b0;
            flags_valid <= 1'b0;
            issue_ready <= 1'b1;
            flags       <= '0;
        end else begin
            wb_valid    <= issue_valid;
            flags_valid <= issue_valid && set_flags;
            // One idle cycle after each accepted micro-op
            issue_ready <= ~issue_valid;
            if (issue_valid && set_flags) begin
                flags <= flags_next;
            end
        end
    end

    // Writeback payload
    always_ff @(posedge clk_in) begin
        if (issue_valid) begin
            wb_index <= issue_dest;
            wb_data  <= result;
        end
    end

    // ************************************************************************
    // Assertions
    // ************************************************************************

    // The scheduler has to respect the throttle, else a read could miss a result
    a_issue_only_when_ready: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        issue_valid |-> issue_ready
    ) else $error("issue_valid raised while issue_ready is low");

    a_wb_single_cycle: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        wb_valid |=> !wb_valid
    ) else $error("wb_valid high for two consecutive cycles");

    // ************************************************************************

endmodule

// File: logic/phys_reg_file.sv
module phys_reg_file
    import exec_pkg::*;
#(
    parameter int NUM_PREGS = 64
) (
    input  logic  clk_in,
    input  logic  rst_n,

    input  preg_t rd_index_a,
    input  preg_t rd_index_b,
    input  preg_t rd_index_c,
    output data_t rd_data_a,
    output data_t rd_data_b,
    output data_t rd_data_c,

    input  logic  wr_en,
    input  preg_t wr_index,
    input  data_t wr_data
);

    data_t regs [NUM_PREGS];

    // An index past the end of a smaller file reads as zero
    always_comb begin
        rd_data_a = (rd_index_a < NUM_PREGS) ? regs[rd_index_a] : '0;
        rd_data_b = (rd_index_b < NUM_PREGS) ? regs[rd_index_b] : '0;
        rd_data_c = (rd_index_c < NUM_PREGS) ? regs[rd_index_c] : '0;
    end

    // Single write port, register 0 included
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_index < NUM_PREGS)) begin
            regs[wr_index] <= wr_data;
        end
    end

    // ************************************************************************
    // Assertions
    // ************************************************************************

    // A destination outside the file means the rename side handed out a bad tag
    a_wr_index_in_range: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        wr_en |-> (wr_index < NUM_PREGS)
    ) else $error("write index %0d outside register file of %0d", wr_index, NUM_PREGS);

endmodule

// File: common/exec_pkg.sv
package exec_pkg;

    localparam int DATA_W = 64;

    // Largest register file the index type can address
    localparam int MAX_PREGS = 64;
    localparam int PREG_W    = $clog2(MAX_PREGS);

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [PREG_W-1:0] preg_t;

    // Condition flags, N in the top bit down to V in bit 0
    typedef logic [3:0] nzcv_t;

    localparam int NZCV_N = 3;
    localparam int NZCV_Z = 2;
    localparam int NZCV_C = 1;
    localparam int NZCV_V = 0;

endpackage

// File: common/uop_pkg.sv
package uop_pkg;

    // Integer micro-op opcodes; any other encoding gives a zero result
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_ORR  = 4'd3,
        ALU_EOR  = 4'd4,
        ALU_MVN  = 4'd5,
        ALU_UBFM = 4'd6,
        ALU_ASR  = 4'd7,
        ALU_MOVZ = 4'd8,
        ALU_MOVK = 4'd9
    } uop_opcode_t;

    typedef logic [15:0] uop_ctrl_t;
    typedef logic [15:0] imm16_t;

    // Bit position inside a 64-bit word, used by the extract bounds
    typedef logic [5:0] bit_pos_t;

    // Half-word select for the move-wide operations
    typedef logic [1:0] hw_sel_t;

    // Control field layout
    localparam int CTRL_LSB_POS       = 0;
    localparam int CTRL_MSB_POS       = 6;
    localparam int CTRL_HW_POS        = 12;
    localparam int CTRL_SET_FLAGS_BIT = 14;
    localparam int CTRL_USE_IMM_BIT   = 15;

    function automatic bit_pos_t ctrl_lsb(uop_ctrl_t ctrl);
        return ctrl[CTRL_LSB_POS +: $bits(bit_pos_t)];
    endfunction

    function automatic bit_pos_t ctrl_msb(uop_ctrl_t ctrl);
        return ctrl[CTRL_MSB_POS +: $bits(bit_pos_t)];
    endfunction

    function automatic hw_sel_t ctrl_hw(uop_ctrl_t ctrl);
        return ctrl[CTRL_HW_POS +: $bits(hw_sel_t)];
    endfunction

    function automatic logic ctrl_set_flags(uop_ctrl_t ctrl);
        return ctrl[CTRL_SET_FLAGS_BIT];
    endfunction

    // When set, operand b comes from the zero-extended immediate
    function automatic logic ctrl_use_imm(uop_ctrl_t ctrl);
        return ctrl[CTRL_USE_IMM_BIT];
    endfunction

endpackage
